//--- source/pong_pkg.sv
package pong_pkg;

    //////////////////////////////
    // Field geometry
    //////////////////////////////

    // Bits per coordinate
    localparam int COORD_W = 7;
    // Playing field in cells
    localparam int FIELD_W = 96;
    localparam int FIELD_H = 64;

    //////////////////////////////
    // Objects
    //////////////////////////////

    // Ball is drawn strictly within this distance of its center
    localparam int BALL_SIZE = 2;
    // Paddle extent in rows and columns
    localparam int PAD_HEIGHT = 12;
    localparam int PAD_WIDTH  = 2;
    // Inner faces of the paddles
    localparam int XPAD_LEFT  = 4;
    localparam int XPAD_RIGHT = 91;

    //////////////////////////////
    // Scores and settings
    //////////////////////////////

    localparam int SCORE_W   = 4;
    localparam int SCORE_MAX = 9;
    localparam int DIFF_W    = 2;
    localparam int STEP_W    = 3;

    // Config bus widths
    localparam int CFG_AW = 2;
    localparam int CFG_DW = 8;
    // Config register map
    localparam logic [CFG_AW-1:0] CFG_RUN  = CFG_AW'(0);
    localparam logic [CFG_AW-1:0] CFG_DIFF = CFG_AW'(1);
    localparam logic [CFG_AW-1:0] CFG_STEP = CFG_AW'(2);

endpackage

//--- source/game_if.sv
interface game_if;
    import pong_pkg::*;

    // Ball center
    logic [COORD_W-1:0] ball_x;
    logic [COORD_W-1:0] ball_y;
    // Paddle center rows
    logic [COORD_W-1:0] ypad_left;
    logic [COORD_W-1:0] ypad_right;

    // Ball mover needs the paddles for bounce tests
    modport ball (
        output ball_x,
        output ball_y,
        input  ypad_left,
        input  ypad_right
    );

    modport paddle (
        output ypad_left,
        output ypad_right
    );

    // Renderer only looks
    modport render (
        input ball_x,
        input ball_y,
        input ypad_left,
        input ypad_right
    );

endinterface

//--- source/game_cfg.sv
module game_cfg (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cfg_we,
    input  logic [pong_pkg::CFG_AW-1:0] cfg_addr,
    input  logic [pong_pkg::CFG_DW-1:0] cfg_wdata,
    output logic                        run,
    output logic [pong_pkg::DIFF_W-1:0] diff,
    output logic [pong_pkg::STEP_W-1:0] pad_step
);
    import pong_pkg::*;

    //////////////////////////////
    // Register writes
    //////////////////////////////

    // One strobe updates one register
    // New value shows the cycle after
    always_ff @(posedge clk) begin
        if (rst) begin
            run      <= 1'b0;
            diff     <= '0;
            // Paddles move one row per frame by default
            pad_step <= STEP_W'(1);
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_RUN: begin
                    run <= cfg_wdata[0];
                end
                CFG_DIFF: begin
                    diff <= cfg_wdata[DIFF_W-1:0];
                end
                CFG_STEP: begin
                    pad_step <= cfg_wdata[STEP_W-1:0];
                end
                default: begin
                    // Unmapped address
                    run <= run;
                end
            endcase
        end
    end

    // Zero step would freeze both paddles for good
    a_step_nonzero: assert property (@(posedge clk) disable iff (rst)
        pad_step != '0);

endmodule

//--- source/paddle_ctrl.sv
module paddle_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        frame_tick,
    input  logic [pong_pkg::STEP_W-1:0] pad_step,
    input  logic                        up_left,
    input  logic                        down_left,
    input  logic                        up_right,
    input  logic                        down_right,
    game_if.paddle                      gb
);
    import pong_pkg::*;

    // Next center row for one paddle
    // Both buttons held cancel out
    function automatic logic [COORD_W-1:0] pad_next(
        input logic [COORD_W-1:0] pos,
        input logic               up,
        input logic               down,
        input logic [STEP_W-1:0]  step
    );
        logic [COORD_W-1:0] res;
        res = pos;
        if (up && !down) begin
            // Up lowers the row number
            if (pos < PAD_HEIGHT / 2 + step) begin
                res = COORD_W'(PAD_HEIGHT / 2);
            end else begin
                res = pos - COORD_W'(step);
            end
        end else if (down && !up) begin
            // Stop with the bottom edge on the last row
            if (pos + step > FIELD_H - PAD_HEIGHT / 2) begin
                res = COORD_W'(FIELD_H - PAD_HEIGHT / 2);
            end else begin
                res = pos + COORD_W'(step);
            end
        end
        return res;
    endfunction

    //////////////////////////////
    // Paddle registers
    //////////////////////////////

    // Start centered, move once per frame
    always_ff @(posedge clk) begin
        if (rst) begin
            gb.ypad_left  <= COORD_W'(FIELD_H / 2);
            gb.ypad_right <= COORD_W'(FIELD_H / 2);
        end else if (frame_tick) begin
            gb.ypad_left  <= pad_next(gb.ypad_left, up_left, down_left, pad_step);
            gb.ypad_right <= pad_next(gb.ypad_right, up_right, down_right, pad_step);
        end
    end

    // Whole paddle stays inside the field on both sides
    a_pad_range: assert property (@(posedge clk) disable iff (rst)
        gb.ypad_left >= PAD_HEIGHT / 2 && gb.ypad_left <= FIELD_H - PAD_HEIGHT / 2 &&
        gb.ypad_right >= PAD_HEIGHT / 2 && gb.ypad_right <= FIELD_H - PAD_HEIGHT / 2);

endmodule

//--- source/ball_motion.sv
module ball_motion (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        frame_tick,
    input  logic                        run,
    input  logic                        game_over,
    input  logic [pong_pkg::DIFF_W-1:0] diff,
    game_if.ball                        gb,
    output logic                        p1_pt,
    output logic                        p2_pt
);
    import pong_pkg::*;

    // Direction flags
    // dx high moves right, dy high moves down
    logic               dx;
    logic               dy;
    // Index of the coming serve
    logic [1:0]         st_state;
    logic [1:0]         st_next;
    logic [COORD_W-1:0] xvel;
    logic               hit_top;
    logic               hit_bot;
    logic               in_left;
    logic               in_right;
    logic               hit_left;
    logic               hit_right;
    logic               miss_left;
    logic               miss_right;
    logic               serve_hold;
    logic               point;
    logic               restart;
    logic               dx_new;
    logic               dy_new;
    logic [COORD_W-1:0] x_next;
    logic [COORD_W-1:0] y_next;

    //////////////////////////////
    // Collision tests
    //////////////////////////////

    // Horizontal speed grows with difficulty
    assign xvel = COORD_W'(diff) + COORD_W'(1);

    // Ball edge touching row 0 or the last row
    assign hit_top = !dy && gb.ball_y < BALL_SIZE;
    assign hit_bot = dy && gb.ball_y >= FIELD_H - BALL_SIZE;

    // Ball row within half a paddle of each center
    assign in_left  = gb.ball_y + PAD_HEIGHT / 2 >= gb.ypad_left &&
                      gb.ball_y <= gb.ypad_left + PAD_HEIGHT / 2;
    assign in_right = gb.ball_y + PAD_HEIGHT / 2 >= gb.ypad_right &&
                      gb.ball_y <= gb.ypad_right + PAD_HEIGHT / 2;

    // Ball edge has reached a paddle face
    assign hit_left  = !dx && gb.ball_x < XPAD_LEFT + BALL_SIZE && in_left;
    assign hit_right = dx && gb.ball_x > XPAD_RIGHT - BALL_SIZE && in_right;

    // Past the back of a paddle
    assign miss_left  = gb.ball_x < XPAD_LEFT - PAD_WIDTH;
    assign miss_right = gb.ball_x > XPAD_RIGHT + PAD_WIDTH;

    //////////////////////////////
    // Next state
    //////////////////////////////

    // Idle or finished match parks the ball
    assign serve_hold = !run || game_over;
    assign point      = !serve_hold && (miss_left || miss_right);
    assign restart    = serve_hold || miss_left || miss_right;
    // Only a scored point moves on to the next serve
    assign st_next    = point ? st_state + 2'd1 : st_state;

    assign dx_new = (hit_left || hit_right) ? !dx : dx;
    assign dy_new = (hit_top || hit_bot) ? !dy : dy;

    // Leftward step stops at column 0 so the miss test sees it
    assign x_next = dx_new ? gb.ball_x + xvel :
                    (gb.ball_x < xvel ? '0 : gb.ball_x - xvel);
    assign y_next = dy_new ? gb.ball_y + COORD_W'(1) : gb.ball_y - COORD_W'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            gb.ball_x <= COORD_W'(FIELD_W / 2);
            gb.ball_y <= COORD_W'(FIELD_H / 2);
            dx        <= 1'b0;
            dy        <= 1'b0;
            st_state  <= 2'd0;
            p1_pt     <= 1'b0;
            p2_pt     <= 1'b0;
        end else begin
            // Exit on the right is a point for player 1
            p1_pt <= frame_tick && point && miss_right;
            p2_pt <= frame_tick && point && miss_left;
            if (frame_tick) begin
                if (restart) begin
                    gb.ball_x <= COORD_W'(FIELD_W / 2);
                    gb.ball_y <= COORD_W'(FIELD_H / 2);
                    // Bit 0 picks right, bit 1 picks down
                    dx        <= st_next[0];
                    dy        <= st_next[1];
                    st_state  <= st_next;
                end else begin
                    gb.ball_x <= x_next;
                    gb.ball_y <= y_next;
                    dx        <= dx_new;
                    dy        <= dy_new;
                end
            end
        end
    end

    // Ball cannot be beyond both paddles in one frame
    a_one_point: assert property (@(posedge clk) disable iff (rst)
        !(p1_pt && p2_pt));

endmodule

//--- source/score_keeper.sv
module score_keeper (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         p1_pt,
    input  logic                         p2_pt,
    output logic [pong_pkg::SCORE_W-1:0] score_p1,
    output logic [pong_pkg::SCORE_W-1:0] score_p2,
    output logic                         game_over
);
    import pong_pkg::*;

    // Either side at the limit ends the match
    assign game_over = (score_p1 == SCORE_W'(SCORE_MAX)) ||
                       (score_p2 == SCORE_W'(SCORE_MAX));

    //////////////////////////////
    // Score counters
    //////////////////////////////

    // Counts freeze once the match is over
    always_ff @(posedge clk) begin
        if (rst) begin
            score_p1 <= '0;
            score_p2 <= '0;
        end else if (!game_over) begin
            if (p1_pt) begin
                score_p1 <= score_p1 + SCORE_W'(1);
            end
            if (p2_pt) begin
                score_p2 <= score_p2 + SCORE_W'(1);
            end
        end
    end

    // Limit holds whatever the point pulses do
    a_score_cap: assert property (@(posedge clk) disable iff (rst)
        score_p1 <= SCORE_MAX && score_p2 <= SCORE_MAX);

endmodule

//--- source/raster_render.sv
module raster_render (
    input  logic                         clk,
    input  logic                         rst,
    game_if.render                       gb,
    output logic [pong_pkg::COORD_W-1:0] scan_x,
    output logic [pong_pkg::COORD_W-1:0] scan_y,
    output logic                         pixel,
    output logic                         frame_tick
);
    import pong_pkg::*;

    logic last_col;
    logic ball_on;
    logic pad_left_on;
    logic pad_right_on;

    // Paddle covers rows center-6 up to center+5
    function automatic logic pad_rows(
        input logic [COORD_W-1:0] y,
        input logic [COORD_W-1:0] ypad
    );
        return (y + PAD_HEIGHT / 2 >= ypad) && (y < ypad + PAD_HEIGHT / 2);
    endfunction

    //////////////////////////////
    // Scan counters
    //////////////////////////////

    assign last_col   = scan_x == COORD_W'(FIELD_W - 1);
    // High on the last cell where the scan wraps
    assign frame_tick = last_col && scan_y == COORD_W'(FIELD_H - 1);

    // Row-major walk of one cell per clock
    always_ff @(posedge clk) begin
        if (rst) begin
            scan_x <= '0;
            scan_y <= '0;
        end else if (last_col) begin
            scan_x <= '0;
            scan_y <= frame_tick ? '0 : scan_y + COORD_W'(1);
        end else begin
            scan_x <= scan_x + COORD_W'(1);
        end
    end

    //////////////////////////////
    // Pixel
    //////////////////////////////

    // Ball square strictly within BALL_SIZE of center
    // Offsets added on the scan side to avoid wrap at column 0
    assign ball_on = scan_x + BALL_SIZE > gb.ball_x && scan_x < gb.ball_x + BALL_SIZE &&
                     scan_y + BALL_SIZE > gb.ball_y && scan_y < gb.ball_y + BALL_SIZE;

    // Paddles sit just outside their faces
    assign pad_left_on  = scan_x >= XPAD_LEFT - PAD_WIDTH && scan_x < XPAD_LEFT &&
                          pad_rows(scan_y, gb.ypad_left);
    assign pad_right_on = scan_x > XPAD_RIGHT && scan_x <= XPAD_RIGHT + PAD_WIDTH &&
                          pad_rows(scan_y, gb.ypad_right);

    assign pixel = ball_on || pad_left_on || pad_right_on;

endmodule

//--- source/pong_top.sv
module pong_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cfg_we,
    input  logic [pong_pkg::CFG_AW-1:0]  cfg_addr,
    input  logic [pong_pkg::CFG_DW-1:0]  cfg_wdata,
    input  logic                         up_left,
    input  logic                         down_left,
    input  logic                         up_right,
    input  logic                         down_right,
    output logic [pong_pkg::COORD_W-1:0] scan_x,
    output logic [pong_pkg::COORD_W-1:0] scan_y,
    output logic                         pixel,
    output logic [pong_pkg::SCORE_W-1:0] score_p1,
    output logic [pong_pkg::SCORE_W-1:0] score_p2,
    output logic                         game_over
);
    import pong_pkg::*;

    logic              frame_tick;
    logic              run;
    logic [DIFF_W-1:0] diff;
    logic [STEP_W-1:0] pad_step;
    // Point pulses from ball to scores
    logic              p1_pt;
    logic              p2_pt;

    // Object positions shared by movers and renderer
    game_if game_bus ();

    game_cfg u_cfg (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .run(run), .diff(diff), .pad_step(pad_step)
    );

    paddle_ctrl u_paddle (
        .clk(clk), .rst(rst), .frame_tick(frame_tick), .pad_step(pad_step),
        .up_left(up_left), .down_left(down_left),
        .up_right(up_right), .down_right(down_right), .gb(game_bus.paddle)
    );

    ball_motion u_ball (
        .clk(clk), .rst(rst), .frame_tick(frame_tick), .run(run),
        .game_over(game_over), .diff(diff), .gb(game_bus.ball),
        .p1_pt(p1_pt), .p2_pt(p2_pt)
    );

    score_keeper u_score (
        .clk(clk), .rst(rst), .p1_pt(p1_pt), .p2_pt(p2_pt),
        .score_p1(score_p1), .score_p2(score_p2), .game_over(game_over)
    );

    raster_render u_render (
        .clk(clk), .rst(rst), .gb(game_bus.render), .scan_x(scan_x),
        .scan_y(scan_y), .pixel(pixel), .frame_tick(frame_tick)
    );

endmodule

//--- tests/pong_tb.sv
module pong_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pong_pkg::*;

    //////////////////////////////
    // Run constants
    //////////////////////////////

    localparam int          CLK_PERIOD   = 4;
    localparam int          DRIVE_DELAY  = 1;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] RAND_SEED    = 32'h121891a8;
    localparam int          FRAME_CYCLES = FIELD_W * FIELD_H;
    // Run budget of 40 frames a point plus margin
    localparam int POINT_FRAMES    = 40;
    localparam int EXPECTED_POINTS = 12;
    localparam int MARGIN_FRAMES   = 20;
    localparam int TIMEOUT_CYCLES  =
        (POINT_FRAMES * EXPECTED_POINTS + MARGIN_FRAMES) * FRAME_CYCLES;
    // Longest rally before giving up on a point
    localparam int RALLY_LIMIT = 300;
    localparam int PAD_TOP     = PAD_HEIGHT / 2;
    localparam int PAD_BOTTOM  = FIELD_H - PAD_HEIGHT / 2;

    // Reference game state updated once per frame tick
    typedef struct {
        int x;
        int y;
        int dx;
        int dy;
        int st;
        int pl;
        int pr;
        int s1;
        int s2;
    } game_state_t;

    logic               clk;
    logic               rst;
    logic               cfg_we;
    logic [CFG_AW-1:0]  cfg_addr;
    logic [CFG_DW-1:0]  cfg_wdata;
    logic               up_left;
    logic               down_left;
    logic               up_right;
    logic               down_right;
    logic [COORD_W-1:0] scan_x;
    logic [COORD_W-1:0] scan_y;
    logic               pixel;
    logic [SCORE_W-1:0] score_p1;
    logic [SCORE_W-1:0] score_p2;
    logic               game_over;

    game_state_t m;
    int          m_run;
    int          m_diff;
    int          m_step;
    // DUT scores as read early in the last scanned frame
    int          seen_s1;
    int          seen_s2;
    bit          seen_over;
    int          err_count;
    int          cycles;

    pong_top dut_i (
        .clk(clk), .rst(rst), .cfg_we(cfg_we), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .up_left(up_left), .down_left(down_left),
        .up_right(up_right), .down_right(down_right), .scan_x(scan_x),
        .scan_y(scan_y), .pixel(pixel), .score_p1(score_p1),
        .score_p2(score_p2), .game_over(game_over)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Failure handling
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "Run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            err_count++;
            $display("[ERROR] %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
            abort_run("Value mismatch, stopping the run");
        end
    endtask

    // Cycle limit
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT_CYCLES) begin
                abort_run("Timeout: the tests did not finish within the cycle limit");
            end
        end
    end

    //////////////////////////////
    // Reference game rules
    //////////////////////////////

    // One paddle clamped so the whole paddle stays on the field
    function automatic int pad_move(input int p, input bit up, input bit down, input int step);
        if (up && !down) begin
            return (p - step < PAD_TOP) ? PAD_TOP : p - step;
        end
        if (down && !up) begin
            return (p + step > PAD_BOTTOM) ? PAD_BOTTOM : p + step;
        end
        return p;
    endfunction

    function automatic bit near_pad(input int y, input int p);
        return (y - p <= PAD_HEIGHT / 2) && (p - y <= PAD_HEIGHT / 2);
    endfunction

    // Frame tick update returning 1 or 2 for the player who scored
    function automatic int game_step(inout game_state_t g, input int run, input int diff,
                                     input int step, input bit ul, input bit dl,
                                     input bit ur, input bit dr);
        int v;
        bit hold;
        bit out_l;
        bit out_r;
        int pt;
        v     = diff + 1;
        hold  = !run || g.s1 == SCORE_MAX || g.s2 == SCORE_MAX;
        out_l = g.x < XPAD_LEFT - PAD_WIDTH;
        out_r = g.x > XPAD_RIGHT + PAD_WIDTH;
        pt    = 0;
        if (hold || out_l || out_r) begin
            // Serve index moves on only after a real point
            if (!hold) begin
                pt   = out_r ? 1 : 2;
                g.st = (g.st + 1) % 4;
            end
            g.x  = FIELD_W / 2;
            g.y  = FIELD_H / 2;
            g.dx = g.st % 2;
            g.dy = g.st / 2;
        end else begin
            // Walls
            if (!g.dy && g.y < BALL_SIZE) begin
                g.dy = 1;
            end else if (g.dy && g.y >= FIELD_H - BALL_SIZE) begin
                g.dy = 0;
            end
            // Paddle faces against the old paddle rows
            if (!g.dx && g.x < XPAD_LEFT + BALL_SIZE && near_pad(g.y, g.pl)) begin
                g.dx = 1;
            end else if (g.dx && g.x > XPAD_RIGHT - BALL_SIZE && near_pad(g.y, g.pr)) begin
                g.dx = 0;
            end
            if (g.dx) begin
                g.x = g.x + v;
            end else begin
                g.x = (g.x > v) ? g.x - v : 0;
            end
            g.y = g.dy ? g.y + 1 : g.y - 1;
        end
        if (pt == 1) begin
            g.s1++;
        end
        if (pt == 2) begin
            g.s2++;
        end
        g.pl = pad_move(g.pl, ul, dl, step);
        g.pr = pad_move(g.pr, ur, dr, step);
        return pt;
    endfunction

    // Ticks until the next point with buttons released
    function automatic int frames_to_point(input game_state_t g, input int run,
                                           input int diff, output int who);
        game_state_t sim;
        int n;
        sim = g;
        n   = 0;
        who = 0;
        while (who == 0 && n < RALLY_LIMIT) begin
            who = game_step(sim, run, diff, m_step, 1'b0, 1'b0, 1'b0, 1'b0);
            n++;
        end
        return n;
    endfunction

    function automatic bit pixel_at(input game_state_t g, input int col, input int row);
        bit ball;
        bit left;
        bit right;
        ball  = col > g.x - BALL_SIZE && col < g.x + BALL_SIZE &&
                row > g.y - BALL_SIZE && row < g.y + BALL_SIZE;
        left  = col >= XPAD_LEFT - PAD_WIDTH && col < XPAD_LEFT &&
                row >= g.pl - PAD_HEIGHT / 2 && row < g.pl + PAD_HEIGHT / 2;
        right = col > XPAD_RIGHT && col <= XPAD_RIGHT + PAD_WIDTH &&
                row >= g.pr - PAD_HEIGHT / 2 && row < g.pr + PAD_HEIGHT / 2;
        return ball || left || right;
    endfunction

    //////////////////////////////
    // Frame stepping
    //////////////////////////////

    // Starts 1 ns after a wrap, checks every cell, ends after the next wrap
    // Optional config write in the first cell
    task automatic scan_frame(input bit wr, input logic [CFG_AW-1:0] addr, input int data);
        for (int row = 0; row < FIELD_H; row++) begin
            for (int col = 0; col < FIELD_W; col++) begin
                if (row == 0 && col == 0 && wr) begin
                    cfg_we    = 1'b1;
                    cfg_addr  = addr;
                    cfg_wdata = CFG_DW'(data);
                end
                if (row == 0 && col == 1) begin
                    cfg_we    = 1'b0;
                    seen_s1   = score_p1;
                    seen_s2   = score_p2;
                    seen_over = game_over;
                    // Point pulse of the last tick has landed by now
                    check("score_p1", score_p1, m.s1);
                    check("score_p2", score_p2, m.s2);
                    check("game_over", game_over, m.s1 == SCORE_MAX || m.s2 == SCORE_MAX);
                end
                check("scan_x", scan_x, col);
                check("scan_y", scan_y, row);
                check("pixel", pixel, pixel_at(m, col, row));
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        if (wr) begin
            case (addr)
                CFG_RUN:  m_run  = data % 2;
                CFG_DIFF: m_diff = data % 4;
                CFG_STEP: m_step = data % 8;
                default:  m_run  = m_run;
            endcase
        end
    endtask

    task automatic frame(input bit wr, input logic [CFG_AW-1:0] addr, input int data);
        scan_frame(wr, addr, data);
        // Apply the tick of the wrap just scanned
        void'(game_step(m, m_run, m_diff, m_step, up_left, down_left, up_right, down_right));
    endtask

    // Plays until the DUT shows a new score and checks the frame count
    task automatic score_next_point(input bit wr, input logic [CFG_AW-1:0] addr,
                                    input int data);
        int run_p;
        int diff_p;
        int who;
        int k;
        int n;
        int s1_0;
        int s2_0;
        run_p  = m_run;
        diff_p = m_diff;
        if (wr && addr == CFG_RUN) begin
            run_p = data % 2;
        end
        if (wr && addr == CFG_DIFF) begin
            diff_p = data % 4;
        end
        k    = frames_to_point(m, run_p, diff_p, who);
        s1_0 = seen_s1;
        s2_0 = seen_s2;
        frame(wr, addr, data);
        n = 1;
        while (seen_s1 == s1_0 && seen_s2 == s2_0) begin
            if (n > RALLY_LIMIT) begin
                abort_run("No point was scored within the rally limit");
            end
            frame(1'b0, CFG_RUN, 0);
            n++;
        end
        // New score shows one frame after the point tick
        check("frames to point", n - 1, k);
        check("score_p1", seen_s1, s1_0 + (who == 1));
        check("score_p2", seen_s2, s2_0 + (who == 2));
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic reset_dut();
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        // Align to the first wrap
        do begin
            @(posedge clk);
            #DRIVE_DELAY;
        end while (!(scan_x == 0 && scan_y == 0));
        void'(game_step(m, m_run, m_diff, m_step, up_left, down_left, up_right, down_right));
    endtask

    task automatic test_reset_state();
        check("score_p1", score_p1, 0);
        check("score_p2", score_p2, 0);
        check("game_over", game_over, 0);
        // Ball at center and paddles in rows 26 to 37
        frame(1'b0, CFG_RUN, 0);
    endtask

    task automatic test_paddle_step();
        int n;
        frame(1'b1, CFG_STEP, 3);
        repeat (3) begin
            n       = $urandom_range(1, 4);
            up_left = 1'b1;
            repeat (n) frame(1'b0, CFG_RUN, 0);
            up_left = 1'b0;
            frame(1'b0, CFG_RUN, 0);
        end
        // Long enough to reach the top clamp
        up_left = 1'b1;
        repeat (10) frame(1'b0, CFG_RUN, 0);
        up_left = 1'b0;
    endtask

    task automatic test_first_serve();
        // Park both paddles at the bottom
        down_left  = 1'b1;
        down_right = 1'b1;
        while (m.pl != PAD_BOTTOM || m.pr != PAD_BOTTOM) begin
            frame(1'b0, CFG_RUN, 0);
        end
        down_left  = 1'b0;
        down_right = 1'b0;
        frame(1'b0, CFG_RUN, 0);
        // Serve goes up and left so player 2 takes it
        score_next_point(1'b1, CFG_RUN, 1);
        check("score_p2 after first serve", seen_s2, 1);
        check("score_p1 after first serve", seen_s1, 0);
    endtask

    task automatic test_difficulty();
        score_next_point(1'b1, CFG_DIFF, 2);
    endtask

    task automatic test_game_over();
        int f1;
        int f2;
        int guard;
        guard = 0;
        while (!seen_over) begin
            if (guard >= 2 * SCORE_MAX) begin
                abort_run("Game over never rose");
            end
            score_next_point(1'b0, CFG_RUN, 0);
            guard++;
        end
        check("winning score", (seen_s1 > seen_s2) ? seen_s1 : seen_s2, SCORE_MAX);
        f1 = seen_s1;
        f2 = seen_s2;
        repeat (3) frame(1'b0, CFG_RUN, 0);
        check("frozen score_p1", seen_s1, f1);
        check("frozen score_p2", seen_s2, f2);
        check("game_over held", seen_over, 1);
        // Run low parks the ball at center
        frame(1'b1, CFG_RUN, 0);
        repeat (2) frame(1'b0, CFG_RUN, 0);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        err_count  = 0;
        rst        = 1'b1;
        cfg_we     = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        up_left    = 1'b0;
        down_left  = 1'b0;
        up_right   = 1'b0;
        down_right = 1'b0;
        m          = '{x: FIELD_W / 2, y: FIELD_H / 2, dx: 0, dy: 0, st: 0,
                       pl: FIELD_H / 2, pr: FIELD_H / 2, s1: 0, s2: 0};
        m_run      = 0;
        m_diff     = 0;
        m_step     = 1;
        seen_s1    = 0;
        seen_s2    = 0;
        seen_over  = 1'b0;
        reset_dut();
        test_reset_state();
        test_paddle_step();
        test_first_serve();
        test_difficulty();
        test_game_over();
        if (err_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("Checks failed");
        end
    end

endmodule

//--- tb.f
source/pong_pkg.sv
source/game_if.sv
source/game_cfg.sv
source/paddle_ctrl.sv
source/ball_motion.sv
source/score_keeper.sv
source/raster_render.sv
source/pong_top.sv
tests/pong_tb.sv
